/* scope_capture.f */
verilog/capture_pkg.sv
verilog/capture_regs.sv
verilog/trigger_unit.sv
verilog/sample_ring.sv
verilog/capture_sequencer.sv
verilog/scope_capture.sv
verification/clock_gen.sv
verification/scope_capture_tb.sv

/* Makefile */
# Verilator flow for the scope capture core
VERILATOR ?= verilator
TOP ?= scope_capture_tb
RTL_TOP ?= scope_capture
FILELIST ?= scope_capture.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
LINT_FLAGS ?= -Wall --timing
VFLAGS ?= --timing --assert -Wno-fatal
PASS_TEXT ?= All tests passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/scope_capture_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module scope_capture_tb import capture_pkg::*;;

    localparam int ADDRESS_WIDTH = 6;
    localparam int N_PIPE = 2;
    localparam int DEPTH = 1 << ADDRESS_WIDTH;
    localparam int APB_LIMIT = 20;
    localparam int SAMPLE_LIMIT = 2000;
    localparam int READ_LIMIT = 4000;

    logic        clock;
    logic        reset;
    in_stream_t  in;
    logic        external_trigger;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        out_ready;
    out_stream_t out;

    // Bookkeeping
    int error_count = 0;
    int check_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    bit timed_out = 1'b0;
    logic [31:0] random_state = 32'd3567;

    // Reference model state, trigger history spans the whole run
    bit          model_prev_above = 1'b0;
    bit          model_have_prev = 1'b0;
    bit          capturing = 1'b0;
    bit          triggered = 1'b0;
    logic        model_source;
    logic        model_slope;
    logic [15:0] model_level;
    int          model_point;
    int          write_pointer = 0;
    int          trigger_index;
    int          model_trigger_address;
    int          post_left;
    sample_t     written [$];

    clock_gen #(
        .PERIOD_NS(8.0)
    ) u_clock_gen (
        .clock(clock)
    );

    scope_capture #(
        .ADDRESS_WIDTH(ADDRESS_WIDTH),
        .N_PIPE(N_PIPE)
    ) u_scope_capture (
        .clock(clock),
        .reset(reset),
        .in(in),
        .external_trigger(external_trigger),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .out_ready(out_ready),
        .out(out)
    );

    // LCG, upper bits are the useful ones
    function automatic logic [31:0] next_random();
        random_state = random_state * 32'd1103515245 + 32'd12345;
        return random_state;
    endfunction

    task automatic report_failure(input string message);
        error_count++;
        $display("%s", message);
    endtask

    task automatic compare_sample(input string name, input sample_t actual, input sample_t expected);
        check_count++;
        if (actual !== expected) begin
            report_failure($sformatf("mismatch %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            report_failure($sformatf("mismatch %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic compare_state(input string name, input capture_state_t actual,
                                 input capture_state_t expected);
        check_count++;
        if (actual !== expected) begin
            report_failure($sformatf("mismatch %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic compare_flag(input string name, input logic actual, input logic expected);
        check_count++;
        if (actual !== expected) begin
            report_failure($sformatf("mismatch %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    // One APB transfer, response taken mid access phase
    task automatic apb_access(input logic [31:0] address, input logic write,
                              input logic [31:0] data, output logic [31:0] read_data,
                              output logic error);
        int cycles;
        @(posedge clock);
        paddr <= address;
        pwrite <= write;
        pwdata <= data;
        psel <= 1'b1;
        penable <= 1'b0;
        @(posedge clock);
        penable <= 1'b1;
        cycles = 0;
        @(negedge clock);
        // Zero wait states expected
        compare_flag("pready", pready, 1'b1);
        while (!pready && cycles < APB_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (!pready) begin
            report_failure($sformatf("APB access to %h never completed", address));
            timed_out = 1'b1;
        end
        read_data = prdata;
        error = pslverr;
        @(posedge clock);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] address, input logic [31:0] data);
        logic [31:0] read_data;
        logic        error;
        apb_access(address, 1'b1, data, read_data, error);
        compare_flag("pslverr", error, 1'b0);
    endtask

    task automatic apb_read_check(input string name, input logic [31:0] address,
                                  input logic [31:0] expected);
        logic [31:0] read_data;
        logic        error;
        apb_access(address, 1'b0, 32'd0, read_data, error);
        compare_word(name, read_data, expected);
        compare_flag("pslverr", error, 1'b0);
    endtask

    // Trigger and window rules applied to each driven sample
    task automatic model_sample(input sample_t sample, input logic ext);
        bit above;
        bit rising;
        bit falling;
        bit hit;
        int n;
        above = sample.data >= model_level;
        rising = model_have_prev && !model_prev_above && above;
        falling = model_have_prev && model_prev_above && !above;
        hit = model_source ? ext : (model_slope ? falling : rising);
        model_prev_above = above;
        model_have_prev = 1'b1;
        if (capturing) begin
            n = written.size();
            written.push_back(sample);
            if (triggered) begin
                post_left--;
            end else if (hit && n >= model_point) begin
                triggered = 1'b1;
                trigger_index = n;
                model_trigger_address = write_pointer;
                post_left = DEPTH - 1 - model_point;
            end
            write_pointer = (write_pointer + 1) % DEPTH;
            if (triggered && post_left == 0) begin
                capturing = 1'b0;
            end
        end
    endtask

    task automatic drive_sample(input sample_t sample, input logic ext);
        @(posedge clock);
        in <= '{valid: 1'b1, sample: sample};
        external_trigger <= ext;
        model_sample(sample, ext);
    endtask

    task automatic drive_gap();
        @(posedge clock);
        in.valid <= 1'b0;
        external_trigger <= 1'b0;
    endtask

    // Take the streamed window and check it beat by beat
    task automatic collect_window(input bit random_ready);
        int          beat;
        int          cycles;
        bit          done;
        logic [31:0] r;
        beat = 0;
        cycles = 0;
        done = 1'b0;
        while (!done && cycles < READ_LIMIT) begin
            @(posedge clock);
            r = next_random();
            out_ready <= random_ready ? r[20] : 1'b1;
            @(negedge clock);
            if (out.valid && out_ready) begin
                if (beat < DEPTH) begin
                    compare_sample($sformatf("out.sample beat %0d", beat), out.sample,
                                   written[trigger_index - model_point + beat]);
                    compare_flag($sformatf("out.last beat %0d", beat), out.last,
                                 beat == DEPTH - 1);
                end else begin
                    report_failure("readout sent more beats than the buffer holds");
                end
                beat++;
                done = out.last || beat > DEPTH;
            end
            cycles++;
        end
        if (!done) begin
            report_failure($sformatf("readout stalled after %0d beats", beat));
            timed_out = 1'b1;
        end
        @(posedge clock);
        out_ready <= 1'b1;
    endtask

    // Arm, feed samples until the window closes, then read it out
    task automatic run_capture(input logic source, input logic slope, input logic [15:0] level,
                               input int point, input bit gaps, input bit alternate,
                               input int ext_index, input bit random_ready);
        sample_t     sample;
        logic [31:0] read_data;
        logic        error;
        int          sent;
        bit          probed;
        model_source = source;
        model_slope = slope;
        model_level = level;
        model_point = point;
        written.delete();
        triggered = 1'b0;
        apb_write(reg_level, {16'd0, level});
        apb_write(reg_trigger_point, point);
        apb_write(reg_control, {29'd0, slope, source, 1'b1});
        capturing = 1'b1;
        // Arm is a strobe and reads back as 0
        apb_read_check("reg_control", reg_control, {29'd0, slope, source, 1'b0});
        apb_access(reg_status, 1'b0, 32'd0, read_data, error);
        compare_state("status.state", capture_state_t'(read_data[2:0]), pre_trigger);
        sent = 0;
        probed = 1'b0;
        while (capturing && sent < SAMPLE_LIMIT) begin
            // Early crossings must not have started acquisition
            if (alternate && !probed && written.size() == point) begin
                drive_gap();
                apb_access(reg_status, 1'b0, 32'd0, read_data, error);
                compare_state("status.state early", capture_state_t'(read_data[2:0]),
                              pre_trigger);
                compare_flag("status.trigger_seen early", read_data[3], 1'b0);
                probed = 1'b1;
            end
            if (gaps && (next_random() >> 16) % 4 == 0) begin
                drive_gap();
            end else begin
                sample = sample_t'(next_random() >> 8);
                // Forced crossings ahead of the trigger point
                if (alternate && written.size() < point) begin
                    sample.data[15] = (written.size() % 2 == 0);
                end
                drive_sample(sample, written.size() == ext_index);
            end
            sent++;
        end
        drive_gap();
        if (capturing) begin
            report_failure("no trigger was accepted within the sample limit");
            timed_out = 1'b1;
        end else begin
            collect_window(random_ready);
            apb_read_check("reg_trigger_address", reg_trigger_address, model_trigger_address);
            apb_access(reg_status, 1'b0, 32'd0, read_data, error);
            compare_state("status.state", capture_state_t'(read_data[2:0]), idle);
            compare_flag("status.trigger_seen", read_data[3], 1'b1);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    initial begin
        int          errors_before;
        logic [31:0] read_data;
        logic        error;
        reset = 1'b1;
        in = '0;
        external_trigger = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        out_ready = 1'b1;
        repeat (16) @(posedge clock);
        reset <= 1'b0;

        // Register access and error responses
        errors_before = error_count;
        apb_read_check("reg_status", reg_status, 32'h0);
        apb_access(reg_status, 1'b0, 32'd0, read_data, error);
        compare_state("status.state", capture_state_t'(read_data[2:0]), idle);
        apb_write(reg_level, 32'h0000_1234);
        apb_read_check("reg_level", reg_level, 32'h0000_1234);
        apb_write(reg_trigger_point, 32'h0000_001F);
        apb_read_check("reg_trigger_point", reg_trigger_point, 32'h0000_001F);
        apb_write(reg_control, 32'h0000_0006);
        apb_read_check("reg_control", reg_control, 32'h0000_0006);
        apb_write(reg_control, 32'h0000_0000);
        apb_access(32'h0000_0014, 1'b0, 32'd0, read_data, error);
        compare_flag("pslverr unmapped", error, 1'b1);
        apb_access(reg_status, 1'b1, 32'h0000_0005, read_data, error);
        compare_flag("pslverr read-only", error, 1'b1);
        apb_access(reg_trigger_address, 1'b1, 32'h0000_0003, read_data, error);
        compare_flag("pslverr read-only", error, 1'b1);
        finish_test("register access", errors_before);

        if (!timed_out) begin
            errors_before = error_count;
            run_capture(1'b0, 1'b0, 16'h8000, 5 + int'(next_random() % 20), 1'b0, 1'b0, -1, 1'b0);
            finish_test("rising level capture", errors_before);
        end

        if (!timed_out) begin
            errors_before = error_count;
            run_capture(1'b0, 1'b1, 16'h8000, 24 + int'(next_random() % 16), 1'b1, 1'b1, -1,
                        1'b0);
            finish_test("falling slope with gaps", errors_before);
        end

        if (!timed_out) begin
            errors_before = error_count;
            run_capture(1'b1, 1'b1, 16'h0000, 10, 1'b0, 1'b0, 17, 1'b0);
            finish_test("external trigger", errors_before);
        end

        if (!timed_out) begin
            errors_before = error_count;
            run_capture(1'b0, 1'b0, 16'h4000, 30 + int'(next_random() % 30), 1'b1, 1'b0, -1,
                        1'b1);
            finish_test("output back-pressure", errors_before);
        end

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clock
);

    // Free-running clock, starts low
    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2.0) clock = ~clock;
    end

endmodule

`default_nettype wire

/* verilog/scope_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module scope_capture import capture_pkg::*; #(
    parameter int ADDRESS_WIDTH = 6,
    parameter int N_PIPE = 2
) (
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire in_stream_t  in,
    input  wire logic        external_trigger,
    input  wire logic [31:0] paddr,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [31:0] pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr,
    input  wire logic        out_ready,
    output out_stream_t      out
);

    capture_config_t          capture_config;
    capture_state_t           state;
    logic                     arm;
    logic                     trigger_hit;
    logic                     trigger_seen;
    logic [ADDRESS_WIDTH-1:0] trigger_address;
    logic                     write_enable;
    logic [ADDRESS_WIDTH-1:0] write_address;
    logic                     read_request;
    logic [ADDRESS_WIDTH-1:0] read_address;
    logic                     read_last;
    logic                     read_accept;
    logic                     out_transfer;

    // Beat leaves the core
    assign out_transfer = out.valid && out_ready;

    capture_regs #(
        .ADDRESS_WIDTH(ADDRESS_WIDTH)
    ) u_capture_regs (
        .clock(clock),
        .reset(reset),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .state(state),
        .trigger_seen(trigger_seen),
        .trigger_address(trigger_address),
        .capture_config(capture_config),
        .arm(arm)
    );

    // Trigger and ring both watch the input stream
    trigger_unit u_trigger_unit (
        .clock(clock),
        .reset(reset),
        .in(in),
        .external_trigger(external_trigger),
        .capture_config(capture_config),
        .trigger_hit(trigger_hit)
    );

    sample_ring #(
        .ADDRESS_WIDTH(ADDRESS_WIDTH),
        .N_PIPE(N_PIPE)
    ) u_sample_ring (
        .clock(clock),
        .reset(reset),
        .in(in),
        .write_enable(write_enable),
        .write_address(write_address),
        .read_request(read_request),
        .read_address(read_address),
        .read_last(read_last),
        .read_accept(read_accept),
        .out_ready(out_ready),
        .out(out)
    );

    capture_sequencer #(
        .ADDRESS_WIDTH(ADDRESS_WIDTH)
    ) u_capture_sequencer (
        .clock(clock),
        .reset(reset),
        .in_valid(in.valid),
        .trigger_hit(trigger_hit),
        .arm(arm),
        .capture_config(capture_config),
        .read_accept(read_accept),
        .out_transfer(out_transfer),
        .write_enable(write_enable),
        .write_address(write_address),
        .read_request(read_request),
        .read_address(read_address),
        .read_last(read_last),
        .state(state),
        .trigger_seen(trigger_seen),
        .trigger_address(trigger_address)
    );

endmodule

`default_nettype wire

/* verilog/capture_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_sequencer import capture_pkg::*; #(
    parameter int ADDRESS_WIDTH = 6
) (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire logic                     in_valid,
    input  wire logic                     trigger_hit,
    input  wire logic                     arm,
    input  wire capture_config_t          capture_config,
    input  wire logic                     read_accept,
    input  wire logic                     out_transfer,
    output logic                          write_enable,
    output logic [ADDRESS_WIDTH-1:0]      write_address,
    output logic                          read_request,
    output logic [ADDRESS_WIDTH-1:0]      read_address,
    output logic                          read_last,
    output capture_state_t                state,
    output logic                          trigger_seen,
    output logic [ADDRESS_WIDTH-1:0]      trigger_address
);

    localparam logic [ADDRESS_WIDTH:0] DEPTH = 1 << ADDRESS_WIDTH;

    logic [ADDRESS_WIDTH-1:0] trigger_point;
    logic [ADDRESS_WIDTH-1:0] post_target;
    logic [ADDRESS_WIDTH:0]   fill_count;
    logic [ADDRESS_WIDTH:0]   post_count;
    logic [ADDRESS_WIDTH:0]   issue_count;
    logic [ADDRESS_WIDTH:0]   transfer_count;
    logic                     trigger_accept;
    logic                     sample_written;

    assign trigger_point = capture_config.trigger_point[ADDRESS_WIDTH-1:0];
    // Samples still needed after the trigger sample
    assign post_target = {ADDRESS_WIDTH{1'b1}} - trigger_point;

    // Hit refers to the sample written one cycle earlier
    assign trigger_accept = (state == pre_trigger) && trigger_hit
                            && (fill_count > {1'b0, trigger_point});

    always_comb begin
        case (state)
            // No post samples wanted means stop writing right away
            pre_trigger: write_enable = !(trigger_accept && post_target == '0);
            acquisition: write_enable = post_count != {1'b0, post_target};
            default: write_enable = 1'b0;
        endcase
    end

    assign sample_written = in_valid && write_enable;
    assign read_request = (state == readout) && (issue_count != DEPTH);
    assign read_last = issue_count == DEPTH - 1'b1;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= idle;
            write_address <= '0;
            read_address <= '0;
            trigger_address <= '0;
            trigger_seen <= 1'b0;
            fill_count <= '0;
            post_count <= '0;
            issue_count <= '0;
            transfer_count <= '0;
        end else begin
            if (sample_written) begin
                write_address <= write_address + 1'b1;
            end
            case (state)
                idle, stopped: begin
                    if (arm) begin
                        state <= pre_trigger;
                        fill_count <= '0;
                        trigger_seen <= 1'b0;
                    end else if (state == stopped) begin
                        // Oldest sample of the window first
                        state <= readout;
                        read_address <= trigger_address - trigger_point;
                        issue_count <= '0;
                        transfer_count <= '0;
                    end
                end
                pre_trigger: begin
                    // Saturates once the ring is full
                    if (sample_written && fill_count != DEPTH) begin
                        fill_count <= fill_count + 1'b1;
                    end
                    if (trigger_accept) begin
                        state <= acquisition;
                        trigger_seen <= 1'b1;
                        trigger_address <= write_address - 1'b1;
                        post_count <= sample_written ? 1 : 0;
                    end
                end
                acquisition: begin
                    if (sample_written) begin
                        post_count <= post_count + 1'b1;
                    end
                    if (post_count == {1'b0, post_target}) begin
                        state <= stopped;
                    end
                end
                readout: begin
                    if (read_request && read_accept) begin
                        read_address <= read_address + 1'b1;
                        issue_count <= issue_count + 1'b1;
                    end
                    // Done once the final beat leaves
                    if (out_transfer) begin
                        transfer_count <= transfer_count + 1'b1;
                        if (transfer_count == DEPTH - 1'b1) begin
                            state <= idle;
                        end
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Ring only written while capturing, never past the window
    write_only_when_capturing: assert property (
        @(posedge clock) disable iff (reset)
        write_enable |-> (state == pre_trigger
                          || (state == acquisition && post_count < {1'b0, post_target}))
    );

endmodule

`default_nettype wire

/* verilog/sample_ring.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_ring import capture_pkg::*; #(
    parameter int ADDRESS_WIDTH = 6,
    parameter int N_PIPE = 2
) (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire in_stream_t               in,
    input  wire logic                     write_enable,
    input  wire logic [ADDRESS_WIDTH-1:0] write_address,
    input  wire logic                     read_request,
    input  wire logic [ADDRESS_WIDTH-1:0] read_address,
    input  wire logic                     read_last,
    output logic                          read_accept,
    input  wire logic                     out_ready,
    output out_stream_t                   out
);

    localparam int DEPTH = 1 << ADDRESS_WIDTH;

    sample_t memory [DEPTH];

    // Stage 0 is the memory output register
    logic [N_PIPE:0] pipe_valid;
    logic [N_PIPE:0] pipe_last;
    sample_t         pipe_sample [N_PIPE+1];

    logic advance;

    // Whole pipeline holds while the output beat waits
    assign advance = !out.valid || out_ready;
    assign read_accept = advance;

    always_ff @(posedge clock) begin
        if (in.valid && write_enable) begin
            memory[write_address] <= in.sample;
        end
    end

    // Payload path
    always_ff @(posedge clock) begin
        if (advance) begin
            pipe_sample[0] <= memory[read_address];
            for (int i = 1; i <= N_PIPE; i++) begin
                pipe_sample[i] <= pipe_sample[i-1];
            end
        end
    end

    // Valid and last tags move with the payload
    always_ff @(posedge clock) begin
        if (reset) begin
            pipe_valid <= '0;
            pipe_last <= '0;
        end else if (advance) begin
            pipe_valid <= {pipe_valid[N_PIPE-1:0], read_request};
            pipe_last <= {pipe_last[N_PIPE-1:0], read_request && read_last};
        end
    end

    assign out.valid = pipe_valid[N_PIPE];
    assign out.last = pipe_last[N_PIPE];
    assign out.sample = pipe_sample[N_PIPE];

    // Held beat must not change until taken
    out_stable_when_held: assert property (
        @(posedge clock) disable iff (reset)
        out.valid && !out_ready |=> $stable(out)
    );

endmodule

`default_nettype wire

/* verilog/trigger_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module trigger_unit import capture_pkg::*; (
    input  wire logic            clock,
    input  wire logic            reset,
    input  wire in_stream_t      in,
    input  wire logic            external_trigger,
    input  wire capture_config_t capture_config,
    output logic                 trigger_hit
);

    logic above;
    logic previous_above;
    logic have_previous;
    logic rising;
    logic falling;
    logic level_hit;

    // Comparison of the current sample
    assign above = in.sample.data >= capture_config.level;

    // Crossing needs a previous valid sample
    assign rising = have_previous && !previous_above && above;
    assign falling = have_previous && previous_above && !above;
    assign level_hit = capture_config.slope ? falling : rising;

    always_ff @(posedge clock) begin
        if (reset) begin
            previous_above <= 1'b0;
            have_previous <= 1'b0;
            trigger_hit <= 1'b0;
        end else begin
            if (in.valid) begin
                previous_above <= above;
                have_previous <= 1'b1;
            end
            // One cycle behind the sample that caused it
            if (capture_config.source) begin
                trigger_hit <= in.valid && external_trigger;
            end else begin
                trigger_hit <= in.valid && level_hit;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/capture_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_regs import capture_pkg::*; #(
    parameter int ADDRESS_WIDTH = 6
) (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire logic [31:0]              paddr,
    input  wire logic                     psel,
    input  wire logic                     penable,
    input  wire logic                     pwrite,
    input  wire logic [31:0]              pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    input  wire capture_state_t           state,
    input  wire logic                     trigger_seen,
    input  wire logic [ADDRESS_WIDTH-1:0] trigger_address,
    output capture_config_t               capture_config,
    output logic                          arm
);

    // Trigger point never reaches past the buffer
    localparam logic [11:0] POINT_MASK = 12'((1 << ADDRESS_WIDTH) - 1);

    logic access;
    logic mapped;
    logic read_only;

    // Access phase of an APB transfer
    assign access = psel && penable;

    always_comb begin
        mapped = 1'b1;
        read_only = 1'b0;
        case (paddr)
            reg_control, reg_level, reg_trigger_point: begin
                read_only = 1'b0;
            end
            reg_status, reg_trigger_address: begin
                read_only = 1'b1;
            end
            default: begin
                mapped = 1'b0;
            end
        endcase
    end

    // No wait states
    assign pready = access;
    assign pslverr = access && (!mapped || (pwrite && read_only));

    // Arm is a strobe, never stored
    assign arm = access && pwrite && (paddr == reg_control) && pwdata[0];

    always_ff @(posedge clock) begin
        if (reset) begin
            capture_config <= '0;
        end else if (access && pwrite) begin
            case (paddr)
                reg_control: begin
                    capture_config.source <= pwdata[1];
                    capture_config.slope <= pwdata[2];
                end
                reg_level: begin
                    capture_config.level <= pwdata[15:0];
                end
                reg_trigger_point: begin
                    capture_config.trigger_point <= pwdata[11:0] & POINT_MASK;
                end
                default: begin
                end
            endcase
        end
    end

    // Read mux, arm bit always reads 0
    always_comb begin
        prdata = '0;
        case (paddr)
            reg_control: prdata = {29'd0, capture_config.slope, capture_config.source, 1'b0};
            reg_level: prdata = {16'd0, capture_config.level};
            reg_trigger_point: prdata = {20'd0, capture_config.trigger_point};
            reg_status: prdata = {28'd0, trigger_seen, state};
            reg_trigger_address: prdata = 32'(trigger_address);
            default: prdata = '0;
        endcase
    end

    // APB setup always precedes enable
    penable_needs_psel: assert property (
        @(posedge clock) disable iff (reset) penable |-> psel
    );

endmodule

`default_nettype wire

/* verilog/capture_pkg.sv */
`default_nettype none

package capture_pkg;

    // One converter sample with its routing tags
    typedef struct packed {
        logic [15:0] data;
        logic [3:0]  dest;
        logic [3:0]  user;
    } sample_t;

    // Input beat, no ready since the source cannot stall
    typedef struct packed {
        logic    valid;
        sample_t sample;
    } in_stream_t;

    // Output beat, ready travels back on its own wire
    typedef struct packed {
        logic    valid;
        logic    last;
        sample_t sample;
    } out_stream_t;

    // Fields software sets through APB
    typedef struct packed {
        logic        source;        // 1 selects the external pin
        logic        slope;         // 1 selects a falling crossing
        logic [15:0] level;
        logic [11:0] trigger_point; // Samples kept before the trigger
    } capture_config_t;

    typedef enum logic [2:0] {
        idle        = 3'd0,
        pre_trigger = 3'd1,
        acquisition = 3'd2,
        stopped     = 3'd3,
        readout     = 3'd4
    } capture_state_t;

    // APB register map
    localparam logic [31:0] reg_control         = 32'h00;
    localparam logic [31:0] reg_level           = 32'h04;
    localparam logic [31:0] reg_trigger_point   = 32'h08;
    localparam logic [31:0] reg_status          = 32'h0C;
    localparam logic [31:0] reg_trigger_address = 32'h10;

endpackage

`default_nettype wire
